// ==== Bender.yml ====
package:
  name: tetris_core

sources:
  - files:
      - hw/tetris_pkg.sv
      - hw/cmd_intake.sv
      - hw/move_candidate.sv
      - hw/collision_check.sv
      - hw/piece_commit.sv
      - hw/board_store.sv
      - hw/tetris_core.sv
  - target: test
    files:
      - tb/tb_tetris_core.sv

// ==== files.f ====
hw/tetris_pkg.sv
hw/cmd_intake.sv
hw/move_candidate.sv
hw/collision_check.sv
hw/piece_commit.sv
hw/board_store.sv
hw/tetris_core.sv
tb/tb_tetris_core.sv

// ==== hw/board_store.sv ====
module board_store
    import tetris_pkg::*;
#(
    parameter int BOARD_COLS = 12,
    parameter int BOARD_ROWS = 20
)
(
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             lock_we,
    input  logic [SHAPE_W-1:0]               lock_shape,
    input  logic signed [ROW_W-1:0]          piece_row,
    input  logic signed [COL_W-1:0]          piece_col,
    output logic [BOARD_COLS*BOARD_ROWS-1:0] board
);

    logic [BOARD_COLS*BOARD_ROWS-1:0] lock_mask;

    // Shape cells placed at the live position, bit = row * BOARD_COLS + col.
    always_comb
    begin
        int abs_row;
        int abs_col;
        lock_mask = '0;
        for (int i = 0; i < SHAPE_W; i++)
        begin
            abs_row = int'(piece_row) + i / SHAPE_DIM;
            abs_col = int'(piece_col) + i % SHAPE_DIM;
            if (lock_shape[i] &&
                abs_row >= 0 && abs_row < BOARD_ROWS &&
                abs_col >= 0 && abs_col < BOARD_COLS)
                lock_mask[abs_row * BOARD_COLS + abs_col] = 1'b1;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
            board <= '0;
        else if (lock_we)
            board <= board | lock_mask;
    end

endmodule

// ==== hw/cmd_intake.sv ====
module cmd_intake
    import tetris_pkg::*;
(
    input  logic             Clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic [CMD_W-1:0] cmd,
    input  logic             done,
    output logic             ack,
    output logic             cmd_valid,
    output logic [CMD_W-1:0] cmd_code
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_BUSY  = 2'd1;
    localparam logic [1:0] ST_ACKED = 2'd2;

    logic [1:0] state;
    logic       start;

    // Idle only exits on req, and acked only returns once req drops.
    assign start = (state == ST_IDLE) && req;

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            ack       <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= start;
            case (state)
                ST_IDLE:
                begin
                    if (req)
                        state <= ST_BUSY;
                end
                ST_BUSY:
                begin
                    if (done)
                    begin
                        state <= ST_ACKED;
                        ack   <= 1'b1;
                    end
                end
                ST_ACKED:
                begin
                    if (!req)
                    begin
                        state <= ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (start)
            cmd_code <= cmd;
    end

    assert property (@(posedge Clk) disable iff (!rst_n) $rose(ack) |-> $past(req));

    // No second command issues before the pipeline returns done.
    assert property (@(posedge Clk) disable iff (!rst_n)
        cmd_valid |=> !cmd_valid ##1 !cmd_valid ##1 (done && !cmd_valid));

endmodule

// ==== hw/collision_check.sv ====
module collision_check
    import tetris_pkg::*;
#(
    parameter int BOARD_COLS = 12,
    parameter int BOARD_ROWS = 20
)
(
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             cand_valid,
    input  logic [CMD_W-1:0]                 cand_code,
    input  logic [SHAPE_W-1:0]               cand_shape,
    input  logic signed [ROW_W-1:0]          cand_row,
    input  logic signed [COL_W-1:0]          cand_col,
    input  logic [BOARD_COLS*BOARD_ROWS-1:0] board,
    output logic                             chk_valid,
    output logic [CMD_W-1:0]                 chk_code,
    output logic                             chk_fits,
    output logic [SHAPE_W-1:0]               chk_shape,
    output logic signed [ROW_W-1:0]          chk_row,
    output logic signed [COL_W-1:0]          chk_col
);

    logic fits;

    // Every set cell must sit inside the walls, above the floor and on a free cell.
    always_comb
    begin
        int abs_row;
        int abs_col;
        fits = 1'b1;
        for (int i = 0; i < SHAPE_W; i++)
        begin
            abs_row = int'(cand_row) + i / SHAPE_DIM;
            abs_col = int'(cand_col) + i % SHAPE_DIM;
            if (cand_shape[i])
            begin
                if (abs_col < 0 || abs_col >= BOARD_COLS ||
                    abs_row < 0 || abs_row >= BOARD_ROWS)
                    fits = 1'b0;
                else if (board[abs_row * BOARD_COLS + abs_col])
                    fits = 1'b0;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
            chk_valid <= 1'b0;
        else
            chk_valid <= cand_valid;
    end

    always_ff @(posedge Clk)
    begin
        if (cand_valid)
        begin
            chk_code  <= cand_code;
            chk_fits  <= fits;
            chk_shape <= cand_shape;
            chk_row   <= cand_row;
            chk_col   <= cand_col;
        end
    end

    // A single-cycle candidate gives a verdict one stage later.
    assert property (@(posedge Clk) disable iff (!rst_n)
        cand_valid |=> chk_valid && !cand_valid);

endmodule

// ==== hw/move_candidate.sv ====
module move_candidate
    import tetris_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  logic [CMD_W-1:0]        cmd_code,
    input  logic [SHAPE_W-1:0]      piece_shape,
    input  logic signed [ROW_W-1:0] piece_row,
    input  logic signed [COL_W-1:0] piece_col,
    output logic                    cand_valid,
    output logic [CMD_W-1:0]        cand_code,
    output logic [SHAPE_W-1:0]      cand_shape,
    output logic signed [ROW_W-1:0] cand_row,
    output logic signed [COL_W-1:0] cand_col
);

    logic [SHAPE_W-1:0]      cw_shape;
    logic [SHAPE_W-1:0]      ccw_shape;
    logic [SHAPE_W-1:0]      next_shape;
    logic signed [ROW_W-1:0] next_row;
    logic signed [COL_W-1:0] next_col;

    // ========================================================================
    // Rotation in the 4x4 box
    // ========================================================================

    // CW moves (r,c) to (c,3-r), CCW moves (r,c) to (3-c,r).
    always_comb
    begin
        for (int r = 0; r < SHAPE_DIM; r++)
        begin
            for (int c = 0; c < SHAPE_DIM; c++)
            begin
                cw_shape[c * SHAPE_DIM + (SHAPE_DIM - 1 - r)] =
                    piece_shape[r * SHAPE_DIM + c];
                ccw_shape[(SHAPE_DIM - 1 - c) * SHAPE_DIM + r] =
                    piece_shape[r * SHAPE_DIM + c];
            end
        end
    end

    // Unknown codes pass the live piece through unchanged.
    always_comb
    begin
        next_shape = piece_shape;
        next_row   = piece_row;
        next_col   = piece_col;
        case (cmd_code)
            CMD_TICK:  next_row   = piece_row + 1'b1;
            CMD_LEFT:  next_col   = piece_col - 1'b1;
            CMD_RIGHT: next_col   = piece_col + 1'b1;
            CMD_CCW:   next_shape = ccw_shape;
            CMD_CW:    next_shape = cw_shape;
            default:   next_shape = piece_shape;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
            cand_valid <= 1'b0;
        else
            cand_valid <= cmd_valid;
    end

    always_ff @(posedge Clk)
    begin
        if (cmd_valid)
        begin
            cand_code  <= cmd_code;
            cand_shape <= next_shape;
            cand_row   <= next_row;
            cand_col   <= next_col;
        end
    end

endmodule

// ==== hw/piece_commit.sv ====
module piece_commit
    import tetris_pkg::*;
#(
    parameter int SPAWN_COL  = 4,
    parameter int BOARD_COLS = 12,
    parameter int BOARD_ROWS = 20
)
(
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             chk_valid,
    input  logic [CMD_W-1:0]                 chk_code,
    input  logic                             chk_fits,
    input  logic [SHAPE_W-1:0]               chk_shape,
    input  logic signed [ROW_W-1:0]          chk_row,
    input  logic signed [COL_W-1:0]          chk_col,
    input  logic [SHAPE_W-1:0]               new_shape,
    input  logic [BOARD_COLS*BOARD_ROWS-1:0] board,
    output logic                             done,
    output logic                             move_ok,
    output logic                             locked,
    output logic                             game_over,
    output logic [SHAPE_W-1:0]               piece_shape,
    output logic signed [ROW_W-1:0]          piece_row,
    output logic signed [COL_W-1:0]          piece_col,
    output logic                             lock_we,
    output logic [SHAPE_W-1:0]               lock_shape
);

    logic cmd_known;
    logic spawn_hit;

    assign cmd_known  = (chk_code <= CMD_CW);
    assign lock_we    = chk_valid && !game_over && (chk_code == CMD_TICK) && !chk_fits;
    assign lock_shape = piece_shape;

    // ========================================================================
    // Spawn test against the board plus the piece being locked
    // ========================================================================

    always_comb
    begin
        int r;
        int c;
        int lr;
        int lc;
        spawn_hit = 1'b0;
        for (int i = 0; i < SHAPE_W; i++)
        begin
            r  = i / SHAPE_DIM;
            c  = SPAWN_COL + i % SHAPE_DIM;
            lr = r - int'(piece_row);
            lc = c - int'(piece_col);
            if (new_shape[i])
            begin
                if (c >= BOARD_COLS || r >= BOARD_ROWS)
                    spawn_hit = 1'b1;
                else if (board[r * BOARD_COLS + c])
                    spawn_hit = 1'b1;
                if (lr >= 0 && lr < SHAPE_DIM && lc >= 0 && lc < SHAPE_DIM &&
                    piece_shape[lr * SHAPE_DIM + lc])
                    spawn_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            piece_shape <= new_shape;
            piece_row   <= '0;
            piece_col   <= COL_W'(SPAWN_COL);
            done        <= 1'b0;
            move_ok     <= 1'b0;
            locked      <= 1'b0;
            game_over   <= 1'b0;
        end
        else
        begin
            done <= chk_valid;
            if (chk_valid)
            begin
                move_ok <= 1'b0;
                locked  <= 1'b0;
                if (!game_over && lock_we)
                begin
                    locked      <= 1'b1;
                    piece_shape <= new_shape;
                    piece_row   <= '0;
                    piece_col   <= COL_W'(SPAWN_COL);
                    game_over   <= spawn_hit;
                end
                else if (!game_over && chk_fits && cmd_known)
                begin
                    move_ok     <= 1'b1;
                    piece_shape <= chk_shape;
                    piece_row   <= chk_row;
                    piece_col   <= chk_col;
                end
            end
        end
    end

    // A lock only follows a tick, so the rejected candidate is the live piece one row down.
    assert property (@(posedge Clk) disable iff (!rst_n)
        lock_we |-> (chk_row == piece_row + 1'b1) && (chk_col == piece_col) &&
        (chk_shape == piece_shape));

endmodule

// ==== hw/tetris_core.sv ====
module tetris_core
    import tetris_pkg::*;
#(
    parameter int BOARD_COLS = 12,
    parameter int BOARD_ROWS = 20,
    parameter int SPAWN_COL  = 4
)
(
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             req,
    input  logic [CMD_W-1:0]                 cmd,
    input  logic [SHAPE_W-1:0]               new_shape,
    output logic                             ack,
    output logic                             move_ok,
    output logic                             locked,
    output logic                             game_over,
    output logic [SHAPE_W-1:0]               piece_shape,
    output logic signed [ROW_W-1:0]          piece_row,
    output logic signed [COL_W-1:0]          piece_col,
    output logic [BOARD_COLS*BOARD_ROWS-1:0] board
);

    logic                    done;
    logic                    cmd_valid;
    logic [CMD_W-1:0]        cmd_code;
    logic                    cand_valid;
    logic [CMD_W-1:0]        cand_code;
    logic [SHAPE_W-1:0]      cand_shape;
    logic signed [ROW_W-1:0] cand_row;
    logic signed [COL_W-1:0] cand_col;
    logic                    chk_valid;
    logic [CMD_W-1:0]        chk_code;
    logic                    chk_fits;
    logic [SHAPE_W-1:0]      chk_shape;
    logic signed [ROW_W-1:0] chk_row;
    logic signed [COL_W-1:0] chk_col;
    logic                    lock_we;
    logic [SHAPE_W-1:0]      lock_shape;

    // ========================================================================
    // Intake, candidate, check, commit
    // ========================================================================

    cmd_intake cmd_intake_inst (
        .Clk, .rst_n, .req, .cmd, .done,
        .ack, .cmd_valid, .cmd_code
    );

    move_candidate move_candidate_inst (
        .Clk, .rst_n, .cmd_valid, .cmd_code,
        .piece_shape, .piece_row, .piece_col,
        .cand_valid, .cand_code, .cand_shape, .cand_row, .cand_col
    );

    collision_check #(.BOARD_COLS(BOARD_COLS), .BOARD_ROWS(BOARD_ROWS)) collision_check_inst (
        .Clk, .rst_n, .cand_valid, .cand_code, .cand_shape, .cand_row, .cand_col, .board,
        .chk_valid, .chk_code, .chk_fits, .chk_shape, .chk_row, .chk_col
    );

    piece_commit #(
        .SPAWN_COL (SPAWN_COL),
        .BOARD_COLS(BOARD_COLS),
        .BOARD_ROWS(BOARD_ROWS)
    ) piece_commit_inst (
        .Clk, .rst_n, .chk_valid, .chk_code, .chk_fits, .chk_shape, .chk_row, .chk_col,
        .new_shape, .board,
        .done, .move_ok, .locked, .game_over,
        .piece_shape, .piece_row, .piece_col, .lock_we, .lock_shape
    );

    // Written on the commit edge with the pre-spawn position.
    board_store #(.BOARD_COLS(BOARD_COLS), .BOARD_ROWS(BOARD_ROWS)) board_store_inst (
        .Clk, .rst_n, .lock_we, .lock_shape, .piece_row, .piece_col, .board
    );

endmodule

// ==== hw/tetris_pkg.sv ====
package tetris_pkg;

    // ========================================================================
    // Host commands
    // ========================================================================

    localparam int CMD_W = 3;

    localparam logic [CMD_W-1:0] CMD_TICK  = 3'd0;
    localparam logic [CMD_W-1:0] CMD_LEFT  = 3'd1;
    localparam logic [CMD_W-1:0] CMD_RIGHT = 3'd2;
    localparam logic [CMD_W-1:0] CMD_CCW   = 3'd3;
    localparam logic [CMD_W-1:0] CMD_CW    = 3'd4;

    // ========================================================================
    // Piece geometry
    // ========================================================================

    // Shape bitmap is 4x4, bit index = row * 4 + col, row 0 on top.
    localparam int SHAPE_DIM = 4;
    localparam int SHAPE_W   = SHAPE_DIM * SHAPE_DIM;

    // Top-left corner of the shape, in cells.
    // Signed so a candidate may step past a wall.
    localparam int ROW_W = 6;
    localparam int COL_W = 6;

endpackage

// ==== tb/tb_tetris_core.sv ====
module tb_tetris_core
    import tetris_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BOARD_COLS  = 12;
    localparam int BOARD_ROWS  = 20;
    localparam int SPAWN_COL   = 4;
    localparam int BOARD_BITS  = BOARD_COLS * BOARD_ROWS;
    localparam int ACK_LATENCY = 5;
    localparam int STEP_BUDGET = 20;
    localparam int WD_MARGIN   = 100;

    // 2x2 block in the top-left of the box, and the I bar in its three poses.
    localparam logic [SHAPE_W-1:0] O_SHAPE = 16'h0033;
    localparam logic [SHAPE_W-1:0] I_VERT  = 16'h1111;
    localparam logic [SHAPE_W-1:0] I_TOP   = 16'h000F;
    localparam logic [SHAPE_W-1:0] I_LOW   = 16'hF000;

    typedef struct {
        logic [CMD_W-1:0]   cmd;
        logic [SHAPE_W-1:0] new_shape;
        logic               exp_ok;
        logic               exp_locked;
        logic               exp_over;
        logic [SHAPE_W-1:0] exp_shape;
        int                 exp_row;
        int                 exp_col;
    } step_t;

    logic                    Clk = 1'b0;
    logic                    rst_n;
    logic                    req;
    logic [CMD_W-1:0]        cmd;
    logic [SHAPE_W-1:0]      new_shape;
    logic                    ack;
    logic                    move_ok;
    logic                    locked;
    logic                    game_over;
    logic [SHAPE_W-1:0]      piece_shape;
    logic signed [ROW_W-1:0] piece_row;
    logic signed [COL_W-1:0] piece_col;
    logic [BOARD_BITS-1:0]   board;

    step_t                 steps[$];
    logic                  steps_ready = 1'b0;
    logic [BOARD_BITS-1:0] exp_board;

    always #2 Clk = ~Clk;

    tetris_core #(
        .BOARD_COLS(BOARD_COLS),
        .BOARD_ROWS(BOARD_ROWS),
        .SPAWN_COL (SPAWN_COL)
    ) tetris_core_inst (
        .Clk, .rst_n, .req, .cmd, .new_shape,
        .ack, .move_ok, .locked, .game_over,
        .piece_shape, .piece_row, .piece_col, .board
    );

    // ========================================================================
    // Reporting and checks
    // ========================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_value(input string name, input logic [BOARD_BITS-1:0] actual,
                               input logic [BOARD_BITS-1:0] expected);
        assert (actual === expected)
        else
            abort_run($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
    endtask

    function automatic void add_step(input logic [CMD_W-1:0] c, input logic ok,
                                     input logic lk, input logic over,
                                     input logic [SHAPE_W-1:0] shape, input int row,
                                     input int col);
        step_t s;
        s.cmd        = c;
        s.new_shape  = I_VERT;
        s.exp_ok     = ok;
        s.exp_locked = lk;
        s.exp_over   = over;
        s.exp_shape  = shape;
        s.exp_row    = row;
        s.exp_col    = col;
        steps.push_back(s);
    endfunction

    // Marks the cells of a locked piece, bit = row * BOARD_COLS + col.
    function automatic void place_expected(input logic [SHAPE_W-1:0] shape, input int row,
                                           input int col);
        for (int i = 0; i < SHAPE_W; i++)
        begin
            if (shape[i])
                exp_board[(row + i / 4) * BOARD_COLS + col + i % 4] = 1'b1;
        end
    endfunction

    // ========================================================================
    // Command table
    // ========================================================================

    function automatic void build_steps();
        int landings[5] = '{16, 12, 8, 4, 0};
        // O piece against both walls, plus one unknown code.
        for (int c = SPAWN_COL - 1; c >= 0; c--)
            add_step(CMD_LEFT, 1'b1, 1'b0, 1'b0, O_SHAPE, 0, c);
        add_step(CMD_LEFT, 1'b0, 1'b0, 1'b0, O_SHAPE, 0, 0);
        add_step(3'd7, 1'b0, 1'b0, 1'b0, O_SHAPE, 0, 0);
        for (int c = 1; c <= 10; c++)
            add_step(CMD_RIGHT, 1'b1, 1'b0, 1'b0, O_SHAPE, 0, c);
        add_step(CMD_RIGHT, 1'b0, 1'b0, 1'b0, O_SHAPE, 0, 10);
        // Gravity to the floor, then the lock spawns an I bar.
        for (int r = 1; r <= 18; r++)
            add_step(CMD_TICK, 1'b1, 1'b0, 1'b0, O_SHAPE, r, 10);
        add_step(CMD_TICK, 1'b0, 1'b1, 1'b0, I_VERT, 0, SPAWN_COL);
        // Rotations in open space.
        add_step(CMD_CW, 1'b1, 1'b0, 1'b0, I_TOP, 0, SPAWN_COL);
        add_step(CMD_CCW, 1'b1, 1'b0, 1'b0, I_VERT, 0, SPAWN_COL);
        add_step(CMD_CCW, 1'b1, 1'b0, 1'b0, I_LOW, 0, SPAWN_COL);
        add_step(CMD_CW, 1'b1, 1'b0, 1'b0, I_VERT, 0, SPAWN_COL);
        // Right wall blocks both the step and the rotations.
        for (int c = SPAWN_COL + 1; c <= 11; c++)
            add_step(CMD_RIGHT, 1'b1, 1'b0, 1'b0, I_VERT, 0, c);
        add_step(CMD_RIGHT, 1'b0, 1'b0, 1'b0, I_VERT, 0, 11);
        add_step(CMD_CW, 1'b0, 1'b0, 1'b0, I_VERT, 0, 11);
        add_step(CMD_CCW, 1'b0, 1'b0, 1'b0, I_VERT, 0, 11);
        // Bar lands on the O piece at rows 18 and 19.
        for (int r = 1; r <= 14; r++)
            add_step(CMD_TICK, 1'b1, 1'b0, 1'b0, I_VERT, r, 11);
        add_step(CMD_TICK, 1'b0, 1'b1, 1'b0, I_VERT, 0, SPAWN_COL);
        // Stack bars in the spawn column until the spawn collides.
        foreach (landings[k])
        begin
            for (int r = 1; r <= landings[k]; r++)
                add_step(CMD_TICK, 1'b1, 1'b0, 1'b0, I_VERT, r, SPAWN_COL);
            add_step(CMD_TICK, 1'b0, 1'b1, landings[k] == 0, I_VERT, 0, SPAWN_COL);
        end
        add_step(CMD_LEFT, 1'b0, 1'b0, 1'b1, I_VERT, 0, SPAWN_COL);
        add_step(CMD_RIGHT, 1'b0, 1'b0, 1'b1, I_VERT, 0, SPAWN_COL);
        add_step(CMD_CW, 1'b0, 1'b0, 1'b1, I_VERT, 0, SPAWN_COL);
        add_step(CMD_CCW, 1'b0, 1'b0, 1'b1, I_VERT, 0, SPAWN_COL);
        add_step(CMD_TICK, 1'b0, 1'b0, 1'b1, I_VERT, 0, SPAWN_COL);
    endfunction

    // One four-phase transaction, entered and left 1 ns after a rising edge.
    task automatic run_step(input step_t s);
        int cycles;
        cycles    = 0;
        cmd       = s.cmd;
        new_shape = s.new_shape;
        req       = 1'b1;
        while (!ack && cycles <= ACK_LATENCY)
        begin
            @(posedge Clk);
            #1;
            cycles++;
        end
        check_value("ack_latency", cycles, ACK_LATENCY);
        check_value("move_ok", move_ok, s.exp_ok);
        check_value("locked", locked, s.exp_locked);
        check_value("game_over", game_over, s.exp_over);
        check_value("piece_shape", piece_shape, s.exp_shape);
        check_value("piece_row", piece_row, s.exp_row);
        check_value("piece_col", piece_col, s.exp_col);
        check_value("board", board, exp_board);
        req = 1'b0;
        @(posedge Clk);
        #1;
        assert (!ack)
        else
            abort_run("ack stayed high one cycle after req was dropped.");
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial
    begin
        logic [SHAPE_W-1:0] prev_shape;
        int                 prev_row;
        int                 prev_col;
        rst_n      = 1'b0;
        req        = 1'b0;
        cmd        = CMD_TICK;
        new_shape  = O_SHAPE;
        exp_board  = '0;
        prev_shape = O_SHAPE;
        prev_row   = 0;
        prev_col   = SPAWN_COL;
        build_steps();
        steps_ready = 1'b1;
        repeat (2) @(posedge Clk);
        #1;
        rst_n = 1'b1;

        // Reset state, with the shape taken from new_shape during reset.
        check_value("ack", ack, 1'b0);
        check_value("move_ok", move_ok, 1'b0);
        check_value("locked", locked, 1'b0);
        check_value("game_over", game_over, 1'b0);
        check_value("board", board, exp_board);
        check_value("piece_shape", piece_shape, O_SHAPE);
        check_value("piece_row", piece_row, 0);
        check_value("piece_col", piece_col, SPAWN_COL);
        new_shape = I_VERT;

        foreach (steps[i])
        begin
            if (steps[i].exp_locked)
                place_expected(prev_shape, prev_row, prev_col);
            run_step(steps[i]);
            prev_shape = steps[i].exp_shape;
            prev_row   = steps[i].exp_row;
            prev_col   = steps[i].exp_col;
        end

        $display("** PASS **");
        $finish;
    end

    initial
    begin
        wait (steps_ready);
        repeat (steps.size() * STEP_BUDGET + WD_MARGIN) @(posedge Clk);
        abort_run("Timeout: the DUT did not finish the command table in time.");
    end

endmodule
